// ==== compile.f ====
src/ram_pkg.sv
src/ram_wr_if.sv
src/ram_rd_ctrl.sv
src/ram_wr_ctrl.sv
src/ram_lane_steer.sv
src/ram_byte_array.sv
src/ram_top.sv
test/tb_ram_top.sv

// ==== Makefile ====
# Verilator build and run for the scratch RAM testbench

VERILATOR ?= verilator
TOP       ?= tb_ram_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_ram_top.sv ====
// Testbench for the scratch RAM
// Directed and random traffic on both ports, checked against a byte model
module tb_ram_top
    import ram_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_DEPTH    = 256;
    localparam int ADDR_W        = $clog2(ADDR_DEPTH);
    localparam int RESET_CYCLES  = 8;
    localparam int DIRECTED_OPS  = 30;
    localparam int RAND_OPS      = 600;
    localparam int CYCLES_PER_OP = 3;
    localparam int CYCLE_LIMIT   =
        4 * (RESET_CYCLES + (DIRECTED_OPS + RAND_OPS) * CYCLES_PER_OP);

    logic                         clk;
    logic                         rst_n;
    logic                         rd_req_i;
    logic [ADDR_W-1:0]            rd_addr_i;
    access_size_e                 rd_size_i;
    dword_t                       rd_data_o;
    logic                         rd_idle_o;
    logic                         rd_valid_o;
    logic                         rd_invalid_o;
    logic                         wr_req_i;
    logic [ADDR_W-1:0]            wr_addr_i;
    access_size_e                 wr_size_i;
    dword_t                       wr_data_i;
    logic                         wr_idle_o;
    logic                         wr_done_o;
    logic                         wr_invalid_o;
    logic [RSVD_COUNT*BYTE_W-1:0] rsvd_regs_o;

    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    byte_t  model [ADDR_DEPTH];   // Expected contents of the storage

    ram_top #(
        .ADDR_DEPTH(ADDR_DEPTH)
    ) u_ram_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_req_i    (rd_req_i),
        .rd_addr_i   (rd_addr_i),
        .rd_size_i   (rd_size_i),
        .rd_data_o   (rd_data_o),
        .rd_idle_o   (rd_idle_o),
        .rd_valid_o  (rd_valid_o),
        .rd_invalid_o(rd_invalid_o),
        .wr_req_i    (wr_req_i),
        .wr_addr_i   (wr_addr_i),
        .wr_size_i   (wr_size_i),
        .wr_data_i   (wr_data_i),
        .wr_idle_o   (wr_idle_o),
        .wr_done_o   (wr_done_o),
        .wr_invalid_o(wr_invalid_o),
        .rsvd_regs_o (rsvd_regs_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // Watchdog on the whole run
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing, %0d errors so far",
                 cycles, errors);
        $display("Simulation failed");
        $finish;
    end

    function automatic int bytes_in_size(input access_size_e size);
        case (size)
            SIZE_BYTE:  return 1;
            SIZE_WORD:  return 4;
            SIZE_DWORD: return 8;
            default:    return 0;   // Unknown size moves nothing
        endcase
    endfunction

    // Off the natural boundary, or no legal size at all
    function automatic logic size_violation(input logic [ADDR_W-1:0] addr,
                                            input access_size_e size);
        int n;
        n = bytes_in_size(size);
        return (n == 0) || ((addr & ADDR_W'(n - 1)) != '0);
    endfunction

    // Aligned-down address, little endian, zero extended
    function automatic dword_t expected_read(input logic [ADDR_W-1:0] addr,
                                             input access_size_e size);
        dword_t            v;
        int                n;
        logic [ADDR_W-1:0] base;
        n    = bytes_in_size(size);
        base = addr & ~ADDR_W'(n - 1);
        v    = '0;
        for (int i = 0; i < n; i++) begin
            v[i*BYTE_W +: BYTE_W] = model[int'(base) + i];
        end
        return v;
    endfunction

    function automatic logic [RSVD_COUNT*BYTE_W-1:0] expected_rsvd();
        logic [RSVD_COUNT*BYTE_W-1:0] v;
        for (int i = 0; i < RSVD_COUNT; i++) begin
            v[i*BYTE_W +: BYTE_W] = model[i];
        end
        return v;
    endfunction

    task automatic check_value(input string name, input dword_t got, input dword_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic write_access(input logic [ADDR_W-1:0] addr, input access_size_e size,
                                input dword_t data, input logic poke);
        logic        bad;
        logic [31:0] r;
        bad = size_violation(addr, size);
        while (!wr_idle_o) @(negedge clk);
        @(posedge clk);
        wr_req_i  <= 1'b1;
        wr_addr_i <= addr;
        wr_size_i <= size;
        wr_data_i <= data;
        @(posedge clk);                        // Accepted here
        wr_req_i <= poke;                      // Lands while busy, must be ignored
        if (poke) begin
            r = $random(seed);
            wr_addr_i <= r[ADDR_W-1:0];
            wr_size_i <= access_size_e'(r[9:8]);
            wr_data_i <= {$random(seed), $random(seed)};
        end
        @(negedge clk);
        check_value("wr_idle_o", wr_idle_o, 1'b0);
        check_value("wr_done_o", wr_done_o, 1'b1);
        check_value("wr_invalid_o", wr_invalid_o, bad);
        if (!bad) begin
            for (int i = 0; i < bytes_in_size(size); i++) begin
                model[int'(addr) + i] = data[i*BYTE_W +: BYTE_W];
            end
        end
        @(posedge clk);
        wr_req_i <= 1'b0;
        @(negedge clk);
        check_value("wr_done_o", wr_done_o, 1'b0);
        check_value("rsvd_regs_o", rsvd_regs_o, expected_rsvd());
    endtask

    task automatic read_access(input logic [ADDR_W-1:0] addr, input access_size_e size,
                               input logic poke);
        logic [31:0] r;
        while (!rd_idle_o) @(negedge clk);
        @(posedge clk);
        rd_req_i  <= 1'b1;
        rd_addr_i <= addr;
        rd_size_i <= size;
        @(posedge clk);                        // Accepted here
        rd_req_i <= poke;
        if (poke) begin
            r = $random(seed);
            rd_addr_i <= r[ADDR_W-1:0];
            rd_size_i <= access_size_e'(r[9:8]);
        end
        @(negedge clk);
        check_value("rd_idle_o", rd_idle_o, 1'b0);
        check_value("rd_valid_o", rd_valid_o, 1'b1);
        check_value("rd_invalid_o", rd_invalid_o, size_violation(addr, size));
        check_value("rd_data_o", rd_data_o, expected_read(addr, size));
        @(posedge clk);
        rd_req_i <= 1'b0;
        @(negedge clk);
        check_value("rd_valid_o", rd_valid_o, 1'b0);
    endtask

    initial begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        access_size_e      size;
        seed      = 32'h52f5;
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        rd_req_i  = 1'b0;
        rd_addr_i = '0;
        rd_size_i = SIZE_BYTE;
        wr_req_i  = 1'b0;
        wr_addr_i = '0;
        wr_size_i = SIZE_BYTE;
        wr_data_i = '0;
        for (int a = 0; a < ADDR_DEPTH; a++) begin
            model[a] = (a < RSVD_COUNT) ? RSVD_DEFAULT[a*BYTE_W +: BYTE_W] : 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // State straight out of reset
        check_value("rsvd_regs_o", rsvd_regs_o, RSVD_DEFAULT);
        check_value("rd_idle_o", rd_idle_o, 1'b1);
        check_value("wr_idle_o", wr_idle_o, 1'b1);
        check_value("rd_valid_o", rd_valid_o, 1'b0);
        check_value("wr_done_o", wr_done_o, 1'b0);
        check_value("rd_invalid_o", rd_invalid_o, 1'b0);
        check_value("wr_invalid_o", wr_invalid_o, 1'b0);

        // Same-size round trips
        write_access(8'h40, SIZE_BYTE, {$random(seed), $random(seed)}, 1'b0);
        read_access(8'h40, SIZE_BYTE, 1'b0);
        write_access(8'h44, SIZE_WORD, {$random(seed), $random(seed)}, 1'b0);
        read_access(8'h44, SIZE_WORD, 1'b0);
        write_access(8'h48, SIZE_DWORD, {$random(seed), $random(seed)}, 1'b0);
        read_access(8'h48, SIZE_DWORD, 1'b0);

        // Cross-size lane placement
        write_access(8'h50, SIZE_DWORD, 64'h8877_6655_4433_2211, 1'b0);
        for (int i = 0; i < LANES; i++) begin
            read_access(ADDR_W'(8'h50 + i), SIZE_BYTE, 1'b0);
        end
        read_access(8'h50, SIZE_WORD, 1'b0);
        read_access(8'h54, SIZE_WORD, 1'b0);
        for (int i = 0; i < 4; i++) begin
            write_access(ADDR_W'(8'h60 + i), SIZE_BYTE, dword_t'(8'hA0 + i), 1'b0);
        end
        read_access(8'h60, SIZE_WORD, 1'b0);

        // Flagged writes leave the contents alone, flagged reads are marked
        write_access(8'h42, SIZE_WORD, {$random(seed), $random(seed)}, 1'b0);
        write_access(8'h4C, SIZE_DWORD, {$random(seed), $random(seed)}, 1'b0);
        write_access(8'h40, SIZE_RSVD, {$random(seed), $random(seed)}, 1'b0);
        read_access(8'h40, SIZE_DWORD, 1'b0);
        read_access(8'h48, SIZE_DWORD, 1'b0);
        read_access(8'h41, SIZE_WORD, 1'b0);
        read_access(8'h44, SIZE_DWORD, 1'b0);
        read_access(8'h40, SIZE_RSVD, 1'b0);

        // Mixed random traffic
        for (int k = 0; k < RAND_OPS; k++) begin
            r    = $random(seed);
            addr = ADDR_W'($random(seed));
            size = access_size_e'(r[1:0]);
            if (size == SIZE_RSVD && r[12]) begin
                size = SIZE_BYTE;
            end
            if (r[4:2] != 3'd0 && size != SIZE_RSVD) begin
                addr = addr & ~ADDR_W'(bytes_in_size(size) - 1);
            end
            if (r[10:8] == 3'd0) begin
                addr[ADDR_W-1:3] = '0;   // Aim at the reserved block
            end
            if (r[11]) begin
                write_access(addr, size, {$random(seed), $random(seed)}, r[7:5] == 3'd0);
            end else begin
                read_access(addr, size, r[7:5] == 3'd0);
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src/ram_top.sv ====
// Byte-addressed scratch RAM with independent read and write ports
// Low bytes double as configuration registers exported on rsvd_regs_o
module ram_top
    import ram_pkg::*;
#(
    parameter int ADDR_DEPTH = 256
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              rd_req_i,
    input  logic [$clog2(ADDR_DEPTH)-1:0]     rd_addr_i,
    input  access_size_e                      rd_size_i,
    output dword_t                            rd_data_o,
    output logic                              rd_idle_o,
    output logic                              rd_valid_o,
    output logic                              rd_invalid_o,
    input  logic                              wr_req_i,
    input  logic [$clog2(ADDR_DEPTH)-1:0]     wr_addr_i,
    input  access_size_e                      wr_size_i,
    input  dword_t                            wr_data_i,
    output logic                              wr_idle_o,
    output logic                              wr_done_o,
    output logic                              wr_invalid_o,
    output logic [RSVD_COUNT*BYTE_W-1:0]      rsvd_regs_o
);

    localparam int ADDR_W = $clog2(ADDR_DEPTH);

    logic [ADDR_W-1:0] rd_buf_addr;
    access_size_e      rd_buf_size;

    ram_wr_if #(.ADDR_W(ADDR_W)) wr_bus ();

    ram_rd_ctrl #(
        .ADDR_W(ADDR_W)
    ) u_rd_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_req_i    (rd_req_i),
        .rd_addr_i   (rd_addr_i),
        .rd_size_i   (rd_size_i),
        .rd_idle_o   (rd_idle_o),
        .rd_valid_o  (rd_valid_o),
        .rd_invalid_o(rd_invalid_o),
        .buf_addr_o  (rd_buf_addr),
        .buf_size_o  (rd_buf_size)
    );

    ram_wr_ctrl #(
        .ADDR_W(ADDR_W)
    ) u_wr_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_req_i    (wr_req_i),
        .wr_addr_i   (wr_addr_i),
        .wr_size_i   (wr_size_i),
        .wr_data_i   (wr_data_i),
        .wr_idle_o   (wr_idle_o),
        .wr_done_o   (wr_done_o),
        .wr_invalid_o(wr_invalid_o),
        .wr          (wr_bus.ctrl)
    );

    ram_byte_array #(
        .ADDR_DEPTH(ADDR_DEPTH),
        .ADDR_W    (ADDR_W)
    ) u_byte_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr_bus.mem),
        .rd_addr_i(rd_buf_addr),
        .rd_size_i(rd_buf_size),
        .rd_data_o(rd_data_o),
        .rsvd_o   (rsvd_regs_o)
    );

endmodule

// ==== src/ram_byte_array.sv ====
// Byte register storage with per-byte reset defaults
// Write side takes committed lanes, read side assembles byte, word or doubleword
module ram_byte_array
    import ram_pkg::*;
#(
    parameter int ADDR_DEPTH = 256,
    parameter int ADDR_W     = $clog2(ADDR_DEPTH)
) (
    input  logic                         clk,
    input  logic                         rst_n,
    ram_wr_if.mem                        wr,
    input  logic [ADDR_W-1:0]            rd_addr_i,
    input  access_size_e                 rd_size_i,
    output dword_t                       rd_data_o,
    output logic [RSVD_COUNT*BYTE_W-1:0] rsvd_o
);

    localparam int LANE_W     = $clog2(LANES);
    localparam int WORD_LANES = LANES / 2;

    byte_t                    mem [ADDR_DEPTH];
    lane_en_t                 lane_en;
    byte_t                    lane_data [LANES];
    logic [ADDR_W-LANE_W-1:0] wr_blk;

    ram_lane_steer #(
        .ADDR_W(ADDR_W)
    ) u_lane_steer (
        .addr_i     (wr.addr),
        .size_i     (wr.size),
        .data_i     (wr.data),
        .lane_en_o  (lane_en),
        .lane_data_o(lane_data)
    );

    assign wr_blk = wr.addr[ADDR_W-1:LANE_W];   // Doubleword block index

    // Synchronous reset into per-byte defaults
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < ADDR_DEPTH; a++) begin
                mem[a] <= byte_t'(RSVD_DEFAULT >> (a * BYTE_W));   // Zero past the reserved bytes
            end
        end else if (wr.commit) begin
            for (int l = 0; l < LANES; l++) begin
                if (lane_en[l]) begin
                    mem[{wr_blk, LANE_W'(l)}] <= lane_data[l];
                end
            end
        end
    end

    // Little-endian read assembly with zero extension
    always_comb begin
        rd_data_o = '0;
        case (rd_size_i)
            SIZE_BYTE: begin
                rd_data_o[BYTE_W-1:0] = mem[rd_addr_i];
            end
            SIZE_WORD: begin
                for (int i = 0; i < WORD_LANES; i++) begin
                    rd_data_o[i*BYTE_W +: BYTE_W] =
                        mem[{rd_addr_i[ADDR_W-1:LANE_W-1], (LANE_W-1)'(i)}];
                end
            end
            SIZE_DWORD: begin
                for (int i = 0; i < LANES; i++) begin
                    rd_data_o[i*BYTE_W +: BYTE_W] = mem[{rd_addr_i[ADDR_W-1:LANE_W], LANE_W'(i)}];
                end
            end
            default: rd_data_o = '0;
        endcase
    end

    for (genvar r = 0; r < RSVD_COUNT; r++) begin : g_rsvd
        assign rsvd_o[r*BYTE_W +: BYTE_W] = mem[r];
    end

endmodule

// ==== src/ram_lane_steer.sv ====
// Byte lane steering for one doubleword block
// Picks the written lanes and routes little-endian source bytes onto them
module ram_lane_steer
    import ram_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic [ADDR_W-1:0] addr_i,
    input  access_size_e      size_i,
    input  dword_t            data_i,
    output lane_en_t          lane_en_o,
    output byte_t             lane_data_o [LANES]
);

    localparam int WORD_LANES = LANES / 2;
    localparam int LANE_W     = $clog2(LANES);

    logic [LANE_W-1:0] lane_sel;

    assign lane_sel = addr_i[LANE_W-1:0];

    always_comb begin
        lane_en_o = '0;
        case (size_i)
            SIZE_BYTE: begin
                lane_en_o[lane_sel] = 1'b1;
            end
            SIZE_WORD: begin
                // Upper or lower half of the block
                if (lane_sel[LANE_W-1]) begin
                    lane_en_o = {{WORD_LANES{1'b1}}, {WORD_LANES{1'b0}}};
                end else begin
                    lane_en_o = {{WORD_LANES{1'b0}}, {WORD_LANES{1'b1}}};
                end
            end
            SIZE_DWORD: lane_en_o = '1;
            default:    lane_en_o = '0;   // Unknown size writes nothing
        endcase
    end

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        always_comb begin
            case (size_i)
                SIZE_BYTE: lane_data_o[l] = data_i[BYTE_W-1:0];   // Byte 0 on every lane
                SIZE_WORD: lane_data_o[l] = data_i[(l % WORD_LANES)*BYTE_W +: BYTE_W];
                default:   lane_data_o[l] = data_i[l*BYTE_W +: BYTE_W];
            endcase
        end
    end

endmodule

// ==== src/ram_wr_ctrl.sv ====
// Write port controller
// Captures a request while idle, checks alignment, then commits or flags it
module ram_wr_ctrl
    import ram_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_req_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  access_size_e      wr_size_i,
    input  dword_t            wr_data_i,
    output logic              wr_idle_o,
    output logic              wr_done_o,
    output logic              wr_invalid_o,
    ram_wr_if.ctrl            wr
);

    ctrl_state_e       state_q;
    logic              accept;
    logic [ADDR_W-1:0] addr_q;
    access_size_e      size_q;
    dword_t            data_q;
    logic              bad_q;     // Alignment verdict of the captured request

    assign accept = wr_req_i && (state_q == ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= wr_addr_i;
            size_q <= wr_size_i;
            data_q <= wr_data_i;
            bad_q  <= misaligned(wr_addr_i[2:0], wr_size_i);
        end
    end

    assign wr_idle_o    = (state_q == ST_IDLE);
    assign wr_done_o    = (state_q == ST_BUSY);
    assign wr_invalid_o = wr_done_o && bad_q;

    // Any flagged access is dropped, storage only sees clean writes
    assign wr.addr   = addr_q;
    assign wr.size   = size_q;
    assign wr.data   = data_q;
    assign wr.commit = wr_done_o && !bad_q;

endmodule

// ==== src/ram_rd_ctrl.sv ====
// Read port controller
// Accepts a request while idle, holds address and size for one result cycle
module ram_rd_ctrl
    import ram_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd_req_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    input  access_size_e      rd_size_i,
    output logic              rd_idle_o,
    output logic              rd_valid_o,
    output logic              rd_invalid_o,
    output logic [ADDR_W-1:0] buf_addr_o,
    output access_size_e      buf_size_o
);

    ctrl_state_e state_q;
    logic        accept;

    assign accept = rd_req_i && (state_q == ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: state_q <= ST_IDLE;   // Result lasts one cycle
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request captured and held through the busy cycle for the read assembly
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr_o <= rd_addr_i;
            buf_size_o <= rd_size_i;
        end
    end

    assign rd_idle_o  = (state_q == ST_IDLE);
    assign rd_valid_o = (state_q == ST_BUSY);

    // Flag travels with the valid pulse
    assign rd_invalid_o = rd_valid_o && misaligned(buf_addr_o[2:0], buf_size_o);

endmodule

// ==== src/ram_wr_if.sv ====
// Committed write from the write controller into the byte storage
// Fields are stable and already aligned whenever commit is high
interface ram_wr_if
    import ram_pkg::*;
#(
    parameter int ADDR_W = 8
) ();

    logic [ADDR_W-1:0] addr;
    access_size_e      size;
    dword_t            data;
    logic              commit;   // Storage writes on this edge

    modport ctrl (
        output addr,
        output size,
        output data,
        output commit
    );

    modport mem (
        input addr,
        input size,
        input data,
        input commit
    );

endinterface

// ==== src/ram_pkg.sv ====
// Scratch RAM shared definitions
// Bus widths, access sizes, controller states and reserved-register defaults
package ram_pkg;

    localparam int BYTE_W  = 8;
    localparam int DWORD_W = 64;
    localparam int LANES   = DWORD_W / BYTE_W;   // Bytes per doubleword block

    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [DWORD_W-1:0] dword_t;
    typedef logic [LANES-1:0]   lane_en_t;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2,
        SIZE_RSVD  = 2'd3    // Never a legal access
    } access_size_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUSY = 1'b1
    } ctrl_state_e;

    // Peripheral config bytes at the bottom of the address space
    localparam int RSVD_COUNT = 4;
    localparam logic [RSVD_COUNT*BYTE_W-1:0] RSVD_DEFAULT = {8'h8F, 8'h23, 8'h23, 8'h00};

    // True for an unknown size or an address off its natural boundary
    function automatic logic misaligned(input logic [2:0] addr_lo, input access_size_e size);
        logic bad;
        case (size)
            SIZE_BYTE:  bad = 1'b0;
            SIZE_WORD:  bad = (addr_lo[1:0] != 2'b00);
            SIZE_DWORD: bad = (addr_lo != 3'b000);
            default:    bad = 1'b1;
        endcase
        return bad;
    endfunction

endpackage
